// ==== Bender.yml ====
package:
  name: cpu_ctrl

sources:
  - target: rtl
    files:
      - verilog/cpu_ctrl_pkg.sv
      - verilog/op_decode.sv
      - verilog/branch_cond.sv
      - verilog/ucode_seq.sv
      - verilog/pshpul_seq.sv
      - verilog/pc_unit.sv
      - verilog/cpu_ctrl.sv

  - target: test
    files:
      - tb/cpu_ctrl_chk.sv
      - tb/cpu_ctrl_tb.sv

// ==== cpu_ctrl.f ====
verilog/cpu_ctrl_pkg.sv
verilog/op_decode.sv
verilog/branch_cond.sv
verilog/ucode_seq.sv
verilog/pshpul_seq.sv
verilog/pc_unit.sv
verilog/cpu_ctrl.sv
tb/cpu_ctrl_chk.sv
tb/cpu_ctrl_tb.sv

// ==== tb/cpu_ctrl_chk.sv ====
// ******************************
// protocol assertions on the control block outputs
// bound to cpu_ctrl, failures counted for the testbench
// ******************************

`timescale 1ns/1ps

module cpu_ctrl_chk (
    input logic clk,
    input logic rst,
    input logic ni,
    input logic wrq,
    input logic pul_en,
    input logic set_i,
    input logic set_f,
    input logic psh_busy
);
    int fail_cnt = 0;

    // a stack cycle is either a write or a read
    wrq_pul_excl: assert property (@(posedge clk) !(wrq && pul_en))
        else begin
            $error("wrq and pul_en high in the same cycle");
            fail_cnt++;
        end

    // instruction cannot end inside the register walk
    ni_not_busy: assert property (@(posedge clk) ni |-> !psh_busy)
        else begin
            $error("ni high while psh_busy is high");
            fail_cnt++;
        end

    set_f_with_i: assert property (@(posedge clk) set_f |-> set_i)
        else begin
            $error("set_f high without set_i");
            fail_cnt++;
        end

    quiet_in_rst: assert property (@(posedge clk)
        rst |-> !(ni || wrq || pul_en || set_i || set_f))
        else begin
            $error("strobe active during reset");
            fail_cnt++;
        end

endmodule

bind cpu_ctrl cpu_ctrl_chk chk_inst (
    .clk      (clk),
    .rst      (rst),
    .ni       (ni),
    .wrq      (wrq),
    .pul_en   (pul_en),
    .set_i    (set_i),
    .set_f    (set_f),
    .psh_busy (psh_busy)
);

// ==== tb/cpu_ctrl_tb.sv ====
// ******************************
// testbench for the instruction control block
// random cen and mem_busy stalls, a reference model of pc,
// ni timing and stack order, checked by immediate assertions
// ******************************

`timescale 1ns/1ps

module cpu_ctrl_tb;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_INSTR    = 400;

    logic     clk = 1'b0;
    logic     rst;
    logic     cen;
    logic     mem_busy;
    logic     halt;
    byte_t    op;
    byte_t    postbyte;
    addr_t    data;
    byte_t    cc;
    logic     irq;
    logic     firq;
    logic     nmi;
    addr_t    pc;
    logic     ni;
    logic     wrq;
    logic     pul_en;
    reg_sel_t stk_sel;
    logic     set_i;
    logic     set_f;
    logic     psh_busy;

    integer   seed;
    int       errors;
    int       burst;
    addr_t    exp_pc;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_ctrl cpu_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .halt     (halt),
        .op       (op),
        .postbyte (postbyte),
        .data     (data),
        .cc       (cc),
        .irq      (irq),
        .firq     (firq),
        .nmi      (nmi),
        .pc       (pc),
        .ni       (ni),
        .wrq      (wrq),
        .pul_en   (pul_en),
        .stk_sel  (stk_sel),
        .set_i    (set_i),
        .set_f    (set_f),
        .psh_busy (psh_busy)
    );

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // 6809 branch table with odd codes inverting the even ones
    function automatic logic cond_taken(input logic [3:0] cond, input byte_t f);
        logic c;
        logic v;
        logic z;
        logic n;
        c = f[CC_C];
        v = f[CC_V];
        z = f[CC_Z];
        n = f[CC_N];
        case (cond)
            4'h0: return 1'b1;
            4'h1: return 1'b0;
            4'h2: return !c && !z;
            4'h3: return c || z;
            4'h4: return !c;
            4'h5: return c;
            4'h6: return !z;
            4'h7: return z;
            4'h8: return !v;
            4'h9: return v;
            4'hA: return !n;
            4'hB: return n;
            4'hC: return n == v;
            4'hD: return n != v;
            4'hE: return !z && (n == v);
            default: return z || (n != v);
        endcase
    endfunction

    // cen high about 80% of the time and mem_busy in short bursts
    task automatic drive_stall;
        if (burst > 0) begin
            mem_busy <= 1'b1;
            burst = burst - 1;
        end else begin
            mem_busy <= 1'b0;
            if ({$random(seed)} % 20 == 0) begin
                burst = 1 + {$random(seed)} % 4;
            end
        end
        cen <= ({$random(seed)} % 5) != 0;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        drive_stall();
        @(negedge clk);
    endtask

    task automatic check_idle;
        check_value("pc", exp_pc, pc);
        check_value("ni", 0, ni);
        check_value("wrq", 0, wrq);
        check_value("pul_en", 0, pul_en);
        check_value("set_i", 0, set_i);
        check_value("set_f", 0, set_f);
        check_value("psh_busy", 0, psh_busy);
    endtask

    // one instruction or interrupt entry checked cycle by cycle
    task automatic exec(input byte_t o, input byte_t pb, input addr_t d, input byte_t c,
                        input logic l_irq, input logic l_firq, input logic l_nmi);
        int_kind_e kind;
        int        len;
        int        done;
        logic      en_now;
        logic      busy_exp;
        logic      push;
        logic      stack;
        addr_t     nxt_pc;
        reg_sel_t  regs[$];
        kind = INT_NONE;
        if (l_nmi) begin
            kind = INT_NMI;
        end else if (l_firq && !c[CC_F]) begin
            kind = INT_FIRQ;
        end else if (l_irq && !c[CC_I]) begin
            kind = INT_IRQ;
        end
        push  = (o[7:4] == 4'h4);
        stack = (kind == INT_NONE) && (push || o[7:4] == 4'h5);
        len   = 1;
        nxt_pc = exp_pc + 16'd1;
        if (kind != INT_NONE) begin
            len = 2;
            nxt_pc = (kind == INT_NMI) ? VEC_NMI : (kind == INT_FIRQ) ? VEC_FIRQ : VEC_IRQ;
        end else if (o[7:4] == 4'h2) begin
            len = 2;
            nxt_pc = exp_pc + 16'd2 + (cond_taken(o[3:0], c) ? {{8{d[7]}}, d[7:0]} : 16'd0);
        end else if (o[7:4] == 4'h3) begin
            len = 3;
            nxt_pc = exp_pc + 16'd3 + (cond_taken(o[3:0], c) ? d : 16'd0);
        end else if (stack) begin
            for (int i = 0; i < 8; i++) begin
                if (pb[push ? 7 - i : i]) begin
                    regs.push_back(reg_sel_t'(push ? 7 - i : i));
                end
            end
            len = 2 + regs.size();
            nxt_pc = exp_pc + 16'd2;
        end
        @(posedge clk);
        op <= o;
        postbyte <= pb;
        data <= d;
        cc <= c;
        irq <= l_irq;
        firq <= l_firq;
        nmi <= l_nmi;
        drive_stall();
        @(negedge clk);
        check_value("pc", exp_pc, pc);
        done = 0;
        forever begin
            en_now = cen && !mem_busy;
            busy_exp = stack && done > 0 && regs.size() > 0;
            check_value("ni", en_now && kind == INT_NONE && done == len - 1, ni);
            check_value("set_i", en_now && kind != INT_NONE && done == 1, set_i);
            check_value("set_f", en_now && (kind == INT_NMI || kind == INT_FIRQ) && done == 1,
                        set_f);
            check_value("psh_busy", busy_exp, psh_busy);
            check_value("wrq", en_now && busy_exp && push, wrq);
            check_value("pul_en", en_now && busy_exp && !push, pul_en);
            if (en_now && busy_exp) begin
                check_value("stk_sel", regs[0], stk_sel);
                void'(regs.pop_front());
            end
            if (en_now && done == len - 1) begin
                break;
            end
            if (en_now) begin
                done++;
            end
            next_cycle();
        end
        exp_pc = nxt_pc;
    endtask

    // halt at the fetch boundary keeps everything frozen
    task automatic hold_halt(input int cycles);
        int   n;
        logic seen;
        @(posedge clk);
        halt <= 1'b1;
        op <= 8'h01;
        irq <= 1'b0;
        firq <= 1'b0;
        nmi <= 1'b0;
        drive_stall();
        @(negedge clk);
        n = 0;
        seen = 1'b0;
        while (n < cycles || !seen) begin
            check_idle();
            seen = seen | (cen & ~mem_busy);
            n++;
            next_cycle();
        end
        @(posedge clk);
        halt <= 1'b0;
        drive_stall();
        @(negedge clk);
        // leaving halt takes one quiet enabled cycle
        while (!(cen && !mem_busy)) begin
            check_idle();
            next_cycle();
        end
        check_idle();
    endtask

    initial begin
        byte_t      o;
        byte_t      pb;
        addr_t      d;
        byte_t      c;
        logic [2:0] lines;
        int         r;
        seed = 32'hd590_be34;
        errors = 0;
        burst = 0;
        exp_pc = 16'h0000;
        rst = 1'b1;
        cen = 1'b0;
        mem_busy = 1'b0;
        halt = 1'b0;
        op = 8'h00;
        postbyte = 8'h00;
        data = 16'h0000;
        cc = 8'h00;
        irq = 1'b0;
        firq = 1'b0;
        nmi = 1'b0;
        // second reset cycle runs with cen high
        @(posedge clk);
        cen <= 1'b1;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst <= 1'b0;
        cen <= 1'b0;
        @(negedge clk);
        check_idle();
        for (int n = 0; n < N_INSTR; n++) begin
            r = {$random(seed)} % 16;
            o = $random(seed);
            pb = $random(seed);
            d = $random(seed);
            c = $random(seed);
            lines = $random(seed);
            if (r < 4) begin
                if (o[7:4] inside {[4'h2:4'h5]}) begin
                    o[7] = 1'b1;
                end
                exec(o, pb, d, c, 1'b0, 1'b0, 1'b0);
            end else if (r < 11) begin
                o[7:4] = (r < 8) ? 4'h2 : 4'h3;
                exec(o, pb, d, c, 1'b0, 1'b0, 1'b0);
            end else if (r < 13) begin
                o[7:4] = (r == 11) ? 4'h4 : 4'h5;
                if ({$random(seed)} % 4 == 0) begin
                    pb = 8'h00;
                end
                exec(o, pb, d, c, 1'b0, 1'b0, 1'b0);
            end else if (r < 15) begin
                exec(8'h12, pb, d, c, lines[0], lines[1], lines[2]);
            end else begin
                hold_halt(4 + {$random(seed)} % 8);
            end
        end
        @(posedge clk);
        cen <= 1'b0;
        @(negedge clk);
        check_value("pc", exp_pc, pc);
        $display("error count: testbench %0d, protocol %0d", errors,
                 cpu_ctrl_inst.chk_inst.fail_cnt);
        if (errors == 0 && cpu_ctrl_inst.chk_inst.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // 40 cycles per instruction covers stalls and halts
    initial begin
        #(CLK_PERIOD * (N_INSTR * 40 + 100));
        $display("watchdog expired, the instruction stream did not finish");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog/branch_cond.sv ====
// ******************************
// 6809 style branch condition evaluator
// cond is the low opcode nibble, odd codes invert even ones
// ******************************

`timescale 1ns/1ps

module branch_cond (
    input  logic [3:0]          cond,
    input  cpu_ctrl_pkg::byte_t cc,
    output logic                taken
);
    import cpu_ctrl_pkg::*;

    logic base;
    logic n_xor_v;

    assign n_xor_v = cc[CC_N] ^ cc[CC_V];

    // even member of each pair
    always_comb begin
        case (cond[3:1])
            // BRA
            3'd0: base = 1'b1;
            // BHI
            3'd1: base = ~(cc[CC_C] | cc[CC_Z]);
            // BCC
            3'd2: base = ~cc[CC_C];
            // BNE
            3'd3: base = ~cc[CC_Z];
            // BVC
            3'd4: base = ~cc[CC_V];
            // BPL
            3'd5: base = ~cc[CC_N];
            // BGE
            3'd6: base = ~n_xor_v;
            // BGT
            default: base = ~(cc[CC_Z] | n_xor_v);
        endcase
    end

    assign taken = base ^ cond[0];

endmodule

// ==== verilog/cpu_ctrl.sv ====
// ******************************
// instruction control block, top level
// decode and arbitration in, sequencers in the middle,
// program counter out
// ******************************

`timescale 1ns/1ps

module cpu_ctrl #(
    parameter cpu_ctrl_pkg::addr_t RESET_PC = 16'h0000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   mem_busy,
    input  logic                   halt,
    input  cpu_ctrl_pkg::byte_t    op,
    input  cpu_ctrl_pkg::byte_t    postbyte,
    input  cpu_ctrl_pkg::addr_t    data,
    input  cpu_ctrl_pkg::byte_t    cc,
    input  logic                   irq,
    input  logic                   firq,
    input  logic                   nmi,
    output cpu_ctrl_pkg::addr_t    pc,
    output logic                   ni,
    output logic                   wrq,
    output logic                   pul_en,
    output cpu_ctrl_pkg::reg_sel_t stk_sel,
    output logic                   set_i,
    output logic                   set_f,
    output logic                   psh_busy
);
    import cpu_ctrl_pkg::*;

    op_class_e op_class;
    int_kind_e int_req;
    int_kind_e vec_kind;
    logic      taken;
    logic      pc_inc;
    logic      pc_rel8;
    logic      pc_rel16;
    logic      pc_vec;
    logic      stack_go;
    logic      stack_pull;

    op_decode op_decode_inst (
        .op       (op),
        .cc       (cc),
        .irq      (irq),
        .firq     (firq),
        .nmi      (nmi),
        .op_class (op_class),
        .int_req  (int_req)
    );

    // condition code sits in the low opcode nibble
    branch_cond branch_cond_inst (
        .cond  (op[3:0]),
        .cc    (cc),
        .taken (taken)
    );

    ucode_seq ucode_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .halt       (halt),
        .op_class   (op_class),
        .int_req    (int_req),
        .taken      (taken),
        .stack_busy (psh_busy),
        .ni         (ni),
        .pc_inc     (pc_inc),
        .pc_rel8    (pc_rel8),
        .pc_rel16   (pc_rel16),
        .pc_vec     (pc_vec),
        .vec_kind   (vec_kind),
        .stack_go   (stack_go),
        .stack_pull (stack_pull),
        .set_i      (set_i),
        .set_f      (set_f)
    );

    pshpul_seq pshpul_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .postbyte   (postbyte),
        .stack_go   (stack_go),
        .stack_pull (stack_pull),
        .stack_busy (psh_busy),
        .stk_sel    (stk_sel),
        .wrq        (wrq),
        .pul_en     (pul_en)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .data     (data),
        .pc_inc   (pc_inc),
        .pc_rel8  (pc_rel8),
        .pc_rel16 (pc_rel16),
        .pc_vec   (pc_vec),
        .vec_kind (vec_kind),
        .pc       (pc)
    );

endmodule

// ==== verilog/cpu_ctrl_pkg.sv ====
// ******************************
// shared types, state encodings and constants of the
// instruction control block; every RTL file imports it
// ******************************

package cpu_ctrl_pkg;

    // program address or 16-bit operand
    typedef logic [15:0] addr_t;

    // opcode, postbyte or flag byte
    typedef logic [7:0] byte_t;

    // register moved by one stack cycle, 0 is CC and 7 is PC
    typedef logic [2:0] reg_sel_t;

    // instruction class from the upper opcode nibble
    typedef enum logic [2:0] {
        OP_NOP,
        OP_BRA8,
        OP_BRA16,
        OP_PSH,
        OP_PUL
    } op_class_e;

    // highest pending unmasked interrupt
    typedef enum logic [1:0] {
        INT_NONE,
        INT_IRQ,
        INT_FIRQ,
        INT_NMI
    } int_kind_e;

    // microcode sequencer states
    typedef enum logic [2:0] {
        S_FETCH,
        S_OPD_LO,
        S_OPD_HI,
        S_BRANCH,
        S_STACK,
        S_INT,
        S_HALT
    } useq_state_e;

    // fixed vector addresses, loaded straight into pc
    localparam addr_t VEC_NMI  = 16'hFFFC;
    localparam addr_t VEC_IRQ  = 16'hFFF8;
    localparam addr_t VEC_FIRQ = 16'hFFF6;

    // condition-code bit positions
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_F = 6;

endpackage

// ==== verilog/op_decode.sv ====
// ******************************
// opcode classifier and interrupt arbiter
// purely combinational, feeds the microcode sequencer
// ******************************

`timescale 1ns/1ps

module op_decode (
    input  cpu_ctrl_pkg::byte_t     op,
    input  cpu_ctrl_pkg::byte_t     cc,
    input  logic                    irq,
    input  logic                    firq,
    input  logic                    nmi,
    output cpu_ctrl_pkg::op_class_e op_class,
    output cpu_ctrl_pkg::int_kind_e int_req
);
    import cpu_ctrl_pkg::*;

    logic firq_ok;
    logic irq_ok;

    // class from the upper nibble
    always_comb begin
        case (op[7:4])
            4'h2: begin
                op_class = OP_BRA8;
            end
            4'h3: begin
                op_class = OP_BRA16;
            end
            4'h4: begin
                op_class = OP_PSH;
            end
            4'h5: begin
                op_class = OP_PUL;
            end
            // everything else runs as a one byte no-op
            default: begin
                op_class = OP_NOP;
            end
        endcase
    end

    // F and I flags mask the two maskable lines
    assign firq_ok = firq & ~cc[CC_F];
    assign irq_ok  = irq  & ~cc[CC_I];

    // fixed priority, nmi cannot be masked
    always_comb begin
        if (nmi) begin
            int_req = INT_NMI;
        end else if (firq_ok) begin
            int_req = INT_FIRQ;
        end else if (irq_ok) begin
            int_req = INT_IRQ;
        end else begin
            int_req = INT_NONE;
        end
    end

endmodule

// ==== verilog/pc_unit.sv ====
// ******************************
// program counter
// byte step plus optional relative offset in one update,
// or a load of the fixed interrupt vector
// ******************************

`timescale 1ns/1ps

module pc_unit #(
    parameter cpu_ctrl_pkg::addr_t RESET_PC = 16'h0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    mem_busy,
    input  cpu_ctrl_pkg::addr_t     data,
    input  logic                    pc_inc,
    input  logic                    pc_rel8,
    input  logic                    pc_rel16,
    input  logic                    pc_vec,
    input  cpu_ctrl_pkg::int_kind_e vec_kind,
    output cpu_ctrl_pkg::addr_t     pc
);
    import cpu_ctrl_pkg::*;

    addr_t step;
    addr_t offset;
    addr_t vector;

    assign step = {15'd0, pc_inc};

    // short offset is sign extended from the low byte
    always_comb begin
        if (pc_rel16) begin
            offset = data;
        end else if (pc_rel8) begin
            offset = {{8{data[7]}}, data[7:0]};
        end else begin
            offset = '0;
        end
    end

    always_comb begin
        case (vec_kind)
            INT_NMI:  vector = VEC_NMI;
            INT_FIRQ: vector = VEC_FIRQ;
            INT_IRQ:  vector = VEC_IRQ;
            default:  vector = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (cen && !mem_busy) begin
            pc <= pc_vec ? vector : pc + step + offset;
        end
    end

endmodule

// ==== verilog/pshpul_seq.sv ====
// ******************************
// push / pull register walker
// loads the postbyte on stack_go, then moves one register
// per enabled cycle until the mask is empty
// ******************************

`timescale 1ns/1ps

module pshpul_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   mem_busy,
    input  cpu_ctrl_pkg::byte_t    postbyte,
    input  logic                   stack_go,
    input  logic                   stack_pull,
    output logic                   stack_busy,
    output cpu_ctrl_pkg::reg_sel_t stk_sel,
    output logic                   wrq,
    output logic                   pul_en
);
    import cpu_ctrl_pkg::*;

    byte_t mask;
    logic  pull_q;
    logic  en;

    assign en         = cen & ~mem_busy;
    assign stack_busy = |mask;

    // push goes from PC down to CC, pull from CC up to PC
    always_comb begin
        stk_sel = '0;
        if (pull_q) begin
            for (int i = 7; i >= 0; i--) begin
                if (mask[i]) begin
                    stk_sel = reg_sel_t'(i);
                end
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (mask[i]) begin
                    stk_sel = reg_sel_t'(i);
                end
            end
        end
    end

    assign wrq    = en & stack_busy & ~pull_q;
    assign pul_en = en & stack_busy &  pull_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mask   <= '0;
            pull_q <= 1'b0;
        end else if (en) begin
            if (stack_go) begin
                mask   <= postbyte;
                pull_q <= stack_pull;
            end else if (stack_busy) begin
                // retire the register just moved
                mask[stk_sel] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/ucode_seq.sv ====
// ******************************
// instruction sequencer, one state step per enabled cycle
// drives pc strobes, ni, the stack walk start and the
// interrupt entry flags
// ******************************

`timescale 1ns/1ps

module ucode_seq (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    mem_busy,
    input  logic                    halt,
    input  cpu_ctrl_pkg::op_class_e op_class,
    input  cpu_ctrl_pkg::int_kind_e int_req,
    input  logic                    taken,
    input  logic                    stack_busy,
    output logic                    ni,
    output logic                    pc_inc,
    output logic                    pc_rel8,
    output logic                    pc_rel16,
    output logic                    pc_vec,
    output cpu_ctrl_pkg::int_kind_e vec_kind,
    output logic                    stack_go,
    output logic                    stack_pull,
    output logic                    set_i,
    output logic                    set_f
);
    import cpu_ctrl_pkg::*;

    useq_state_e state;
    useq_state_e state_nx;
    op_class_e   cls_q;
    int_kind_e   int_q;
    logic        run;
    logic        en;
    logic        start;

    // run keeps the strobes quiet for the first clock out of reset
    assign en       = cen & ~mem_busy & run;
    assign start    = (state == S_FETCH) & ~halt & (int_req == INT_NONE);
    assign vec_kind = int_q;

    always_comb begin
        state_nx = state;
        case (state)
            S_FETCH: begin
                if (halt) begin
                    state_nx = S_HALT;
                end else if (int_req != INT_NONE) begin
                    state_nx = S_INT;
                end else begin
                    case (op_class)
                        OP_BRA8:  state_nx = S_BRANCH;
                        OP_BRA16: state_nx = S_OPD_HI;
                        OP_PSH:   state_nx = S_OPD_LO;
                        OP_PUL:   state_nx = S_OPD_LO;
                        default:  state_nx = S_FETCH;
                    endcase
                end
            end
            S_OPD_HI: state_nx = S_BRANCH;
            // postbyte cycle overlaps the first register move
            S_OPD_LO: state_nx = stack_busy ? S_STACK : S_FETCH;
            S_STACK:  state_nx = stack_busy ? S_STACK : S_FETCH;
            S_HALT:   state_nx = halt ? S_HALT : S_FETCH;
            default:  state_nx = S_FETCH;
        endcase
    end

    // strobes only in enabled cycles
    always_comb begin
        pc_inc     = en & (start | (state == S_OPD_HI) | (state == S_BRANCH) |
                           (state == S_OPD_LO));
        pc_rel8    = en & (state == S_BRANCH) & taken & (cls_q == OP_BRA8);
        pc_rel16   = en & (state == S_BRANCH) & taken & (cls_q == OP_BRA16);
        pc_vec     = en & (state == S_INT);
        set_i      = en & (state == S_INT);
        set_f      = en & (state == S_INT) & (int_q != INT_IRQ);
        stack_go   = en & start & ((op_class == OP_PSH) | (op_class == OP_PUL));
        stack_pull = en & start & (op_class == OP_PUL);
        ni         = en & ((start & (op_class == OP_NOP)) | (state == S_BRANCH) |
                           (((state == S_OPD_LO) | (state == S_STACK)) & ~stack_busy));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FETCH;
            cls_q <= OP_NOP;
            int_q <= INT_NONE;
            run   <= 1'b0;
        end else begin
            run <= 1'b1;
            if (en) begin
                state <= state_nx;
                // class and interrupt kind held for the rest of the sequence
                if (state == S_FETCH) begin
                    cls_q <= op_class;
                    int_q <= int_req;
                end
            end
        end
    end

endmodule
